// File: source/sd_cmd_pkg.sv
package sd_cmd_pkg;

    localparam int CMD_FRAME_W = 48;
    localparam int CMD_INDEX_W = 6;
    localparam int CMD_ARG_W   = 32;
    localparam int CRC7_W      = 7;

    localparam logic [CRC7_W-1:0] CRC7_POLY = 7'h09; // x^7 + x^3 + 1, top term implied

    localparam int INT_W            = 4;
    localparam int INT_CMD_COMPLETE = 0;
    localparam int INT_CRC_ERR      = 1;
    localparam int INT_INDEX_ERR    = 2;
    localparam int INT_TIMEOUT      = 3;

    typedef enum logic {
        RESP_NONE,
        RESP_SHORT
    } resp_kind_e;

    typedef enum logic [1:0] {
        RX_IDLE,
        RX_WAIT_START,
        RX_SHIFT
    } rx_state_e;

    // one serial step of the CMD line CRC, msb first
    function automatic logic [CRC7_W-1:0] crc7_step(
        input logic [CRC7_W-1:0] crc,
        input logic              din
    );
        logic fb;
        fb = din ^ crc[CRC7_W-1];
        crc7_step = {crc[CRC7_W-2:0], 1'b0} ^ (fb ? CRC7_POLY : '0);
    endfunction

endpackage

// File: source/sd_cmd_tracker.sv
module sd_cmd_tracker
    import sd_cmd_pkg::*;
(
    input  logic             sd_clk,
    input  logic             reset_i,
    input  logic             cmd_start_i,
    input  logic [INT_W-1:0] int_enable_i,
    input  logic [INT_W-1:0] int_clear_i,
    input  logic             no_resp_end_i,
    input  logic             timeout_i,
    input  logic             check_done_i,
    input  logic             crc_ok_i,
    input  logic             index_ok_i,
    output logic             cmd_accept_o,
    output logic             inhibit_o,
    output logic [INT_W-1:0] int_status_o,
    output logic             interrupt_o
);

    logic             end_evt;
    logic [INT_W-1:0] set_bits;

    assign cmd_accept_o = cmd_start_i & ~inhibit_o; // busy host drops the request
    assign end_evt      = no_resp_end_i | timeout_i | check_done_i;

    always_comb begin
        set_bits                   = '0;
        set_bits[INT_CMD_COMPLETE] = no_resp_end_i | check_done_i;
        set_bits[INT_CRC_ERR]      = check_done_i & ~crc_ok_i;
        set_bits[INT_INDEX_ERR]    = check_done_i & ~index_ok_i;
        set_bits[INT_TIMEOUT]      = timeout_i;
    end

    always_ff @(posedge sd_clk) begin
        if (reset_i) begin
            inhibit_o    <= 1'b0;
            int_status_o <= '0;
        end else begin
            if (cmd_accept_o) begin
                inhibit_o <= 1'b1;
            end else if (end_evt) begin
                inhibit_o <= 1'b0;
            end
            int_status_o <= (int_status_o & ~int_clear_i) | set_bits; // set beats clear
        end
    end

    assign interrupt_o = |(int_status_o & int_enable_i);

endmodule

// File: source/sd_cmd_framer.sv
module sd_cmd_framer
    import sd_cmd_pkg::*;
(
    input  logic                   sd_clk,
    input  logic                   reset_i,
    input  logic                   cmd_accept_i,
    input  logic [CMD_INDEX_W-1:0] cmd_index_i,
    input  logic [CMD_ARG_W-1:0]   cmd_arg_i,
    input  resp_kind_e             resp_kind_i,
    output logic                   frame_valid_o,
    output logic [CMD_FRAME_W-1:0] frame_o,
    output resp_kind_e             resp_kind_o,
    output logic [CMD_INDEX_W-1:0] index_o
);

    localparam int BODY_W = CMD_FRAME_W - CRC7_W - 1;

    logic [BODY_W-1:0] body;
    logic [CRC7_W-1:0] crc;

    assign body = {1'b0, 1'b1, cmd_index_i, cmd_arg_i}; // start, host direction

    always_comb begin
        crc = '0;
        for (int i = BODY_W - 1; i >= 0; i--) begin
            crc = crc7_step(crc, body[i]);
        end
    end

    always_ff @(posedge sd_clk) begin
        if (reset_i) begin
            frame_valid_o <= 1'b0;
        end else begin
            frame_valid_o <= cmd_accept_i;
        end
    end

    always_ff @(posedge sd_clk) begin
        if (cmd_accept_i) begin
            frame_o     <= {body, crc, 1'b1}; // end bit last
            resp_kind_o <= resp_kind_i;
            index_o     <= cmd_index_i;
        end
    end

endmodule

// File: source/sd_cmd_shifter.sv
module sd_cmd_shifter
    import sd_cmd_pkg::*;
(
    input  logic                   sd_clk,
    input  logic                   reset_i,
    input  logic                   frame_valid_i,
    input  logic [CMD_FRAME_W-1:0] frame_i,
    input  resp_kind_e             resp_kind_i,
    input  logic [CMD_INDEX_W-1:0] index_i,
    output logic                   cmd_o,
    output logic                   cmd_oe_o,
    output logic                   rx_arm_o,
    output logic                   no_resp_end_o,
    output logic [CMD_INDEX_W-1:0] sent_index_o
);

    localparam int CNT_W = $clog2(CMD_FRAME_W);
    localparam logic [CNT_W-1:0] FIRST_CNT = CNT_W'(CMD_FRAME_W - 1);

    logic [CMD_FRAME_W-1:0] shift_q;
    logic [CNT_W-1:0]       bit_cnt;
    resp_kind_e             kind_q;

    assign cmd_o = cmd_oe_o ? shift_q[CMD_FRAME_W-1] : 1'b1; // line idles high

    always_ff @(posedge sd_clk) begin
        rx_arm_o      <= 1'b0;
        no_resp_end_o <= 1'b0;
        if (reset_i) begin
            cmd_oe_o <= 1'b0;
            bit_cnt  <= '0;
        end else if (frame_valid_i) begin
            cmd_oe_o <= 1'b1;
            bit_cnt  <= FIRST_CNT;
        end else if (cmd_oe_o) begin
            if (bit_cnt == '0) begin
                // last bit is on the line now
                cmd_oe_o      <= 1'b0;
                rx_arm_o      <= (kind_q == RESP_SHORT);
                no_resp_end_o <= (kind_q == RESP_NONE);
            end else begin
                bit_cnt <= bit_cnt - 1'b1;
            end
        end
    end

    always_ff @(posedge sd_clk) begin
        if (frame_valid_i) begin
            shift_q      <= frame_i;
            kind_q       <= resp_kind_i;
            sent_index_o <= index_i; // held for the response check
        end else if (cmd_oe_o) begin
            shift_q <= {shift_q[CMD_FRAME_W-2:0], 1'b1};
        end
    end

endmodule

// File: source/sd_resp_receiver.sv
module sd_resp_receiver
    import sd_cmd_pkg::*;
#(
    parameter int RESP_TIMEOUT = 64
) (
    input  logic                   sd_clk,
    input  logic                   reset_i,
    input  logic                   rx_arm_i,
    input  logic                   cmd_i,
    output logic                   resp_done_o,
    output logic [CMD_FRAME_W-1:0] resp_o,
    output logic                   timeout_o
);

    localparam int TMO_W = $clog2(RESP_TIMEOUT);
    localparam logic [TMO_W-1:0] TMO_LAST = TMO_W'(RESP_TIMEOUT - 2);
    localparam int CNT_W = $clog2(CMD_FRAME_W);
    localparam logic [CNT_W-1:0] LAST_BIT = CNT_W'(CMD_FRAME_W - 1);

    rx_state_e              state_q;
    logic [TMO_W-1:0]       tmo_cnt;
    logic [CNT_W-1:0]       bit_cnt;
    logic [CMD_FRAME_W-1:0] resp_q;

    always_ff @(posedge sd_clk) begin
        resp_done_o <= 1'b0;
        timeout_o   <= 1'b0;
        if (reset_i) begin
            state_q <= RX_IDLE;
            tmo_cnt <= '0;
            bit_cnt <= '0;
        end else begin
            case (state_q)
                RX_IDLE: begin
                    if (rx_arm_i) begin
                        state_q <= RX_WAIT_START;
                        tmo_cnt <= '0;
                    end
                end
                RX_WAIT_START: begin
                    if (!cmd_i) begin
                        state_q <= RX_SHIFT;
                        bit_cnt <= CNT_W'(1); // start bit already taken
                    end else if (tmo_cnt == TMO_LAST) begin
                        state_q   <= RX_IDLE;
                        timeout_o <= 1'b1; // card never answered
                    end else begin
                        tmo_cnt <= tmo_cnt + 1'b1;
                    end
                end
                RX_SHIFT: begin
                    if (bit_cnt == LAST_BIT) begin
                        state_q     <= RX_IDLE;
                        resp_done_o <= 1'b1;
                    end
                    bit_cnt <= bit_cnt + 1'b1;
                end
                default: state_q <= RX_IDLE;
            endcase
        end
    end

    always_ff @(posedge sd_clk) begin
        if (state_q == RX_SHIFT || (state_q == RX_WAIT_START && !cmd_i)) begin
            resp_q <= {resp_q[CMD_FRAME_W-2:0], cmd_i};
        end
    end

    assign resp_o = resp_q;

endmodule

// File: source/sd_resp_checker.sv
module sd_resp_checker
    import sd_cmd_pkg::*;
(
    input  logic                   sd_clk,
    input  logic                   reset_i,
    input  logic                   resp_done_i,
    input  logic [CMD_FRAME_W-1:0] resp_i,
    input  logic [CMD_INDEX_W-1:0] sent_index_i,
    output logic                   check_done_o,
    output logic                   crc_ok_o,
    output logic                   index_ok_o,
    output logic [CMD_ARG_W-1:0]   card_status_o
);

    localparam int CRC_LSB  = 1;
    localparam int IDX_LSB  = CMD_ARG_W + CRC7_W + 1;
    localparam int STAT_LSB = CRC7_W + 1;

    logic [CRC7_W-1:0] crc_calc;

    // crc covers everything ahead of the crc field
    always_comb begin
        crc_calc = '0;
        for (int i = CMD_FRAME_W - 1; i >= STAT_LSB; i--) begin
            crc_calc = crc7_step(crc_calc, resp_i[i]);
        end
    end

    always_ff @(posedge sd_clk) begin
        if (reset_i) begin
            check_done_o <= 1'b0;
            crc_ok_o     <= 1'b0;
            index_ok_o   <= 1'b0;
        end else begin
            check_done_o <= resp_done_i;
            if (resp_done_i) begin
                crc_ok_o   <= (crc_calc == resp_i[CRC_LSB +: CRC7_W]);
                index_ok_o <= (resp_i[IDX_LSB +: CMD_INDEX_W] == sent_index_i);
            end
        end
    end

    // status word is kept even when a check fails
    always_ff @(posedge sd_clk) begin
        if (check_done_o) begin
            card_status_o <= resp_i[STAT_LSB +: CMD_ARG_W];
        end
    end

endmodule

// File: source/sd_cmd_host.sv
module sd_cmd_host
    import sd_cmd_pkg::*;
#(
    parameter int RESP_TIMEOUT = 64
) (
    input  logic                   sd_clk,
    input  logic                   reset_i,
    input  logic                   cmd_start_i,
    input  logic [CMD_INDEX_W-1:0] cmd_index_i,
    input  logic [CMD_ARG_W-1:0]   cmd_arg_i,
    input  resp_kind_e             resp_kind_i,
    input  logic [INT_W-1:0]       int_enable_i,
    input  logic [INT_W-1:0]       int_clear_i,
    input  logic                   cmd_i,
    output logic                   cmd_o,
    output logic                   cmd_oe_o,
    output logic                   inhibit_o,
    output logic [INT_W-1:0]       int_status_o,
    output logic [CMD_ARG_W-1:0]   response_o,
    output logic                   interrupt_o
);

    logic                   cmd_accept;
    logic                   frame_valid;
    logic [CMD_FRAME_W-1:0] frame;
    resp_kind_e             resp_kind;
    logic [CMD_INDEX_W-1:0] frame_index;
    logic                   rx_arm;
    logic                   no_resp_end;
    logic [CMD_INDEX_W-1:0] sent_index;
    logic                   resp_done;
    logic [CMD_FRAME_W-1:0] resp;
    logic                   timeout;
    logic                   check_done;
    logic                   crc_ok;
    logic                   index_ok;

    sd_cmd_tracker i_tracker (
        .sd_clk        (sd_clk),
        .reset_i       (reset_i),
        .cmd_start_i   (cmd_start_i),
        .int_enable_i  (int_enable_i),
        .int_clear_i   (int_clear_i),
        .no_resp_end_i (no_resp_end),
        .timeout_i     (timeout),
        .check_done_i  (check_done),
        .crc_ok_i      (crc_ok),
        .index_ok_i    (index_ok),
        .cmd_accept_o  (cmd_accept),
        .inhibit_o     (inhibit_o),
        .int_status_o  (int_status_o),
        .interrupt_o   (interrupt_o)
    );

    sd_cmd_framer i_framer (
        .sd_clk        (sd_clk),
        .reset_i       (reset_i),
        .cmd_accept_i  (cmd_accept),
        .cmd_index_i   (cmd_index_i),
        .cmd_arg_i     (cmd_arg_i),
        .resp_kind_i   (resp_kind_i),
        .frame_valid_o (frame_valid),
        .frame_o       (frame),
        .resp_kind_o   (resp_kind),
        .index_o       (frame_index)
    );

    sd_cmd_shifter i_shifter (
        .sd_clk        (sd_clk),
        .reset_i       (reset_i),
        .frame_valid_i (frame_valid),
        .frame_i       (frame),
        .resp_kind_i   (resp_kind),
        .index_i       (frame_index),
        .cmd_o         (cmd_o),
        .cmd_oe_o      (cmd_oe_o),
        .rx_arm_o      (rx_arm),
        .no_resp_end_o (no_resp_end),
        .sent_index_o  (sent_index)
    );

    sd_resp_receiver #(
        .RESP_TIMEOUT (RESP_TIMEOUT)
    ) i_receiver (
        .sd_clk      (sd_clk),
        .reset_i     (reset_i),
        .rx_arm_i    (rx_arm),
        .cmd_i       (cmd_i),
        .resp_done_o (resp_done),
        .resp_o      (resp),
        .timeout_o   (timeout)
    );

    sd_resp_checker i_checker (
        .sd_clk        (sd_clk),
        .reset_i       (reset_i),
        .resp_done_i   (resp_done),
        .resp_i        (resp),
        .sent_index_i  (sent_index),
        .check_done_o  (check_done),
        .crc_ok_o      (crc_ok),
        .index_ok_o    (index_ok),
        .card_status_o (response_o)
    );

endmodule

// File: verification/sd_cmd_host_tb.sv
module sd_cmd_host_tb
    import sd_cmd_pkg::*;
();

    localparam int RESP_TIMEOUT = 64;
    localparam int N_CMDS       = 40;
    localparam int CYCLE_LIMIT  = N_CMDS * 2 * (CMD_FRAME_W + RESP_TIMEOUT + 13);

    localparam int MODE_NONE    = 0; // no response expected
    localparam int MODE_GOOD    = 1;
    localparam int MODE_BAD_CRC = 2;
    localparam int MODE_BAD_IDX = 3;
    localparam int MODE_SILENT  = 4;

    logic                   sd_clk = 1'b0;
    logic                   reset_i;
    logic                   cmd_start_i;
    logic [CMD_INDEX_W-1:0] cmd_index_i;
    logic [CMD_ARG_W-1:0]   cmd_arg_i;
    resp_kind_e             resp_kind_i;
    logic [INT_W-1:0]       int_enable_i;
    logic [INT_W-1:0]       int_clear_i;
    logic                   cmd_i = 1'b1;
    logic                   cmd_o;
    logic                   cmd_oe_o;
    logic                   inhibit_o;
    logic [INT_W-1:0]       int_status_o;
    logic [CMD_ARG_W-1:0]   response_o;
    logic                   interrupt_o;

    logic [31:0]            rng = 32'd34106;
    int                     errors = 0;
    int                     cyc = 0;
    int                     card_mode;
    logic [CMD_ARG_W-1:0]   card_status;
    int                     card_delay;
    int                     crc_flip;

    logic                   accept;
    logic                   end_evt;
    logic                   card_answers;
    logic                   exp_busy;
    int                     exp_mode;
    logic [CMD_INDEX_W-1:0] exp_idx;
    logic [CMD_FRAME_W-1:0] exp_tok;
    logic [INT_W-1:0]       exp_status;
    int                     end_at;
    logic                   chk_resp;

    logic [CMD_FRAME_W-1:0] tok_cap;
    int                     oe_len;
    logic [CMD_FRAME_W-1:0] card_tok;
    int                     card_wait;
    int                     card_bits;
    int                     card_end_at;
    logic [CMD_ARG_W-1:0]   resp_status;

    always #20 sd_clk = ~sd_clk;

    sd_cmd_host #(
        .RESP_TIMEOUT (RESP_TIMEOUT)
    ) i_sd_cmd_host (
        .sd_clk       (sd_clk),
        .reset_i      (reset_i),
        .cmd_start_i  (cmd_start_i),
        .cmd_index_i  (cmd_index_i),
        .cmd_arg_i    (cmd_arg_i),
        .resp_kind_i  (resp_kind_i),
        .int_enable_i (int_enable_i),
        .int_clear_i  (int_clear_i),
        .cmd_i        (cmd_i),
        .cmd_o        (cmd_o),
        .cmd_oe_o     (cmd_oe_o),
        .inhibit_o    (inhibit_o),
        .int_status_o (int_status_o),
        .response_o   (response_o),
        .interrupt_o  (interrupt_o)
    );

    function automatic logic [31:0] xorshift32(input logic [31:0] x);
        logic [31:0] y;
        y = x ^ (x << 13);
        y = y ^ (y >> 17);
        y = y ^ (y << 5);
        return y;
    endfunction

    // x^7 + x^3 + 1 over a 40 bit body msb first
    function automatic logic [6:0] crc7_of(input logic [39:0] bits);
        logic [6:0] crc;
        logic       fb;
        crc = '0;
        for (int i = 39; i >= 0; i--) begin
            fb  = bits[i] ^ crc[6];
            crc = {crc[5:0], 1'b0};
            if (fb) begin
                crc = crc ^ 7'h09;
            end
        end
        return crc;
    endfunction

    function automatic logic [47:0] make_token(input logic [5:0] idx, input logic [31:0] arg);
        logic [39:0] body;
        body = {2'b01, idx, arg};
        return {body, crc7_of(body), 1'b1};
    endfunction

    function automatic logic [47:0] make_response(input logic [5:0] idx,
                                                  input logic [31:0] status,
                                                  input int mode, input int flip);
        logic [39:0] body;
        logic [6:0]  crc;
        body = {2'b00, (mode == MODE_BAD_IDX) ? (idx ^ 6'h2a) : idx, status};
        crc  = crc7_of(body);
        if (mode == MODE_BAD_CRC) begin
            crc = crc ^ (7'd1 << flip);
        end
        return {body, crc, 1'b1};
    endfunction

    function automatic logic [INT_W-1:0] expected_bits(input int mode);
        logic [INT_W-1:0] bits;
        bits = '0;
        if (mode == MODE_SILENT) begin
            bits[INT_TIMEOUT] = 1'b1;
        end else begin
            bits[INT_CMD_COMPLETE] = 1'b1;
        end
        if (mode == MODE_BAD_CRC) begin
            bits[INT_CRC_ERR] = 1'b1;
        end
        if (mode == MODE_BAD_IDX) begin
            bits[INT_INDEX_ERR] = 1'b1;
        end
        return bits;
    endfunction

    task automatic report_error(input string msg);
        errors++;
        $display("[ERROR] %0t: %s", $time, msg);
    endtask

    assign accept       = cmd_start_i && !exp_busy;
    assign card_answers = exp_mode == MODE_GOOD || exp_mode == MODE_BAD_CRC
                          || exp_mode == MODE_BAD_IDX;
    assign end_evt      = exp_busy && (cyc == (card_answers ? card_end_at : end_at));

    // reference model of inhibit and sticky status
    always @(posedge sd_clk) begin
        if (reset_i) begin
            exp_busy   <= 1'b0;
            exp_mode   <= MODE_NONE;
            exp_status <= '0;
            end_at     <= 0;
            chk_resp   <= 1'b0;
        end else begin
            chk_resp   <= end_evt && card_answers;
            exp_status <= (exp_status & ~int_clear_i) | (end_evt ? expected_bits(exp_mode) : '0);
            if (accept) begin
                exp_busy <= 1'b1;
                exp_mode <= card_mode;
                exp_idx  <= cmd_index_i;
                exp_tok  <= make_token(cmd_index_i, cmd_arg_i);
                end_at   <= cyc + 50 + ((card_mode == MODE_SILENT) ? RESP_TIMEOUT : 0);
            end else if (end_evt) begin
                exp_busy <= 1'b0;
            end
        end
    end

    // card model capturing the token and answering after card_delay cycles
    always @(posedge sd_clk) begin
        if (reset_i) begin
            cmd_i       <= 1'b1;
            oe_len      <= 0;
            card_wait   <= 0;
            card_bits   <= 0;
            card_end_at <= 0;
        end else begin
            if (cmd_oe_o) begin
                tok_cap <= {tok_cap[CMD_FRAME_W-2:0], cmd_o};
                oe_len  <= oe_len + 1;
            end else begin
                oe_len <= 0;
            end
            if (card_wait == 1) begin
                cmd_i       <= card_tok[CMD_FRAME_W-1]; // start bit
                card_tok    <= {card_tok[CMD_FRAME_W-2:0], 1'b1};
                card_bits   <= CMD_FRAME_W - 1;
                card_end_at <= cyc + 50;
            end else if (card_bits != 0) begin
                cmd_i     <= card_tok[CMD_FRAME_W-1];
                card_tok  <= {card_tok[CMD_FRAME_W-2:0], 1'b1};
                card_bits <= card_bits - 1;
            end else begin
                cmd_i <= 1'b1;
            end
            if (card_wait != 0) begin
                card_wait <= card_wait - 1;
            end
            if (!cmd_oe_o && oe_len != 0 && card_answers) begin
                card_tok    <= make_response(exp_idx, card_status, exp_mode, crc_flip);
                resp_status <= card_status;
                card_wait   <= card_delay;
            end
        end
    end

    always @(posedge sd_clk) begin
        cyc <= cyc + 1;
        if (cyc == CYCLE_LIMIT) begin
            $display("Run hung: the commands did not finish within %0d cycles", CYCLE_LIMIT);
            $display("Something failed");
            $finish;
        end
    end

    token_start_ck: assert property (@(posedge sd_clk) disable iff (reset_i)
        $rose(cmd_oe_o) |-> $past(accept, 2))
        else report_error("CMD line driven without an accepted request");
    token_follow_ck: assert property (@(posedge sd_clk) disable iff (reset_i)
        $past(accept, 2) |-> $rose(cmd_oe_o))
        else report_error("token did not start two cycles after accept");
    token_len_ck: assert property (@(posedge sd_clk) disable iff (reset_i)
        $fell(cmd_oe_o) |-> oe_len == CMD_FRAME_W)
        else report_error("cmd_oe_o was not high for 48 cycles");
    token_bits_ck: assert property (@(posedge sd_clk) disable iff (reset_i)
        $fell(cmd_oe_o) |-> tok_cap == exp_tok)
        else report_error("command token bits differ from reference");
    cmd_idle_ck: assert property (@(posedge sd_clk) disable iff (reset_i)
        !cmd_oe_o |-> cmd_o)
        else report_error("cmd_o not high while idle");
    inhibit_ck: assert property (@(posedge sd_clk) disable iff (reset_i)
        inhibit_o == exp_busy)
        else report_error("inhibit_o differs from reference");
    status_ck: assert property (@(posedge sd_clk) disable iff (reset_i)
        int_status_o == exp_status)
        else report_error("int_status_o differs from reference");
    irq_ck: assert property (@(posedge sd_clk) disable iff (reset_i)
        interrupt_o == |(exp_status & int_enable_i))
        else report_error("interrupt_o is not the masked OR of expected status");
    response_ck: assert property (@(posedge sd_clk) disable iff (reset_i)
        chk_resp |-> response_o == resp_status)
        else report_error("response_o differs from card status word");

    task automatic run_command(input int mode);
        int gap;
        @(posedge sd_clk);
        rng = xorshift32(rng);
        cmd_start_i  <= 1'b1;
        cmd_index_i  <= rng[5:0];
        card_delay   <= 2 + int'(rng[12:8] % 5'd19);
        crc_flip     <= int'(rng[18:16]) % 7;
        int_enable_i <= rng[23:20];
        gap = 1 + int'(rng[28:24]);
        rng = xorshift32(rng);
        cmd_arg_i    <= rng;
        resp_kind_i  <= (mode == MODE_NONE) ? RESP_NONE : RESP_SHORT;
        card_mode    <= mode;
        rng = xorshift32(rng);
        card_status  <= rng;
        @(posedge sd_clk);
        cmd_start_i <= 1'b0;
        repeat (gap) @(posedge sd_clk);
        cmd_start_i <= 1'b1; // host busy so this one is dropped
        @(posedge sd_clk);
        cmd_start_i <= 1'b0;
        do begin
            @(posedge sd_clk);
            rng = xorshift32(rng);
            if (rng[3:0] == 4'd0) begin
                int_clear_i <= rng[7:4];
            end else begin
                int_clear_i <= '0;
            end
        end while (inhibit_o);
        @(posedge sd_clk);
        int_clear_i <= '1;
        @(posedge sd_clk);
        int_clear_i <= '0;
    endtask

    initial begin
        reset_i      = 1'b1;
        cmd_start_i  = 1'b0;
        cmd_index_i  = '0;
        cmd_arg_i    = '0;
        resp_kind_i  = RESP_NONE;
        int_enable_i = '0;
        int_clear_i  = '0;
        card_mode    = MODE_NONE;
        card_status  = '0;
        card_delay   = 2;
        crc_flip     = 0;
        repeat (5) @(posedge sd_clk);
        reset_i <= 1'b0;
        for (int n = 0; n < N_CMDS; n++) begin
            run_command(n % 5);
        end
        repeat (4) @(posedge sd_clk);
        $display("%0d commands run, %0d errors", N_CMDS, errors);
        if (errors == 0) begin
            $display("Everything OK");
        end else begin
            $display("Something failed");
        end
        $finish;
    end

endmodule

// File: all.f
source/sd_cmd_pkg.sv
source/sd_cmd_tracker.sv
source/sd_cmd_framer.sv
source/sd_cmd_shifter.sv
source/sd_resp_receiver.sv
source/sd_resp_checker.sv
source/sd_cmd_host.sv
verification/sd_cmd_host_tb.sv

// File: run.sh
#!/usr/bin/env bash
set -o pipefail
cd "$(dirname "$0")" || exit 1
rm -f sim.log
verilator --binary --assert --top-module sd_cmd_host_tb -f all.f -Mdir obj_dir -o sd_cmd_host_sim \
    && ./obj_dir/sd_cmd_host_sim | tee sim.log \
    || { echo "build or simulation did not complete"; exit 1; }
grep -q "Something failed" sim.log && { echo "FAIL"; exit 1; } || { echo "PASS"; exit 0; }
